//--- Makefile
# Verilator build for the wave-table fetch testbench
VERILATOR ?= verilator
TOP ?= psgWaveFetchTb
FILELIST ?= src.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -Wno-fatal
EXTRA_FLAGS ?=

SIM = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) $(EXTRA_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# the simulator exits non-zero on any $fatal, so make fails with it
run: compile
	./$(SIM)

clean:
	rm -rf $(BUILD_DIR)

//--- logic/psgBusArb.sv
`timescale 1ns/1ps
`default_nettype none

module psgBusArb #(
	parameter int numChannels = 8,
	localparam int selWidth = (numChannels > 1) ? $clog2(numChannels) : 1
) (
	input logic clk,
	input logic rst,
	input logic ce,
	input logic busDone,
	input logic [numChannels-1:0] req,
	output logic [numChannels-1:0] sel,
	output logic [selWidth-1:0] seln
);

	logic [selWidth-1:0] winner;
	logic anyReq;

	// ==========================================================
	// priority pick
	// ==========================================================
	// scan from the top so the lowest requester is written last
	always_comb begin
		winner = '0;
		anyReq = 1'b0;
		for (int i = numChannels - 1; i >= 0; i--) begin
			if (req[i]) begin
				winner = selWidth'(i);
				anyReq = 1'b1;
			end
		end
	end

	// ==========================================================
	// grant register
	// ==========================================================
	// grant only moves between transfers on a sample tick
	always_ff @(posedge clk) begin
		if (rst) begin
			sel <= '0;
			seln <= '0;
		end else if (ce && busDone && anyReq) begin
			sel <= numChannels'(1) << winner;
			seln <= winner;
		end
		// with nobody asking the last owner keeps the bus
	end

	// ==========================================================
	// checks
	// ==========================================================
	// one owner at most, and the index names it
	selOneHot: assert property (@(posedge clk) disable iff (rst)
		$onehot0(sel) && ((sel == '0) || sel[seln]));

	// no re-arbitration mid transfer or between ticks
	selHold: assert property (@(posedge clk) disable iff (rst)
		!(ce && busDone) |=> $stable(sel) && $stable(seln));

endmodule

`default_nettype wire

//--- logic/psgBusMaster.sv
`timescale 1ns/1ps
`default_nettype none

module psgBusMaster #(
	parameter int numChannels = 8,
	localparam int selWidth = (numChannels > 1) ? $clog2(numChannels) : 1
) (
	input logic clk,
	input logic rst,
	input logic [selWidth-1:0] seln,
	input logic [numChannels-1:0] req,
	input psgPkg::psgBusReq_s busReq [numChannels],
	input logic sysAck,
	input psgPkg::psgSample_t sysDat,
	output logic sysCyc,
	output logic [psgPkg::psgAdrWidth-1:0] sysAdr,
	output logic [numChannels-1:0] fill,
	output psgPkg::psgSample_t fillData,
	output logic busDone
);

	typedef enum logic {
		StIdle,
		StWait
	} mstState_e;

	mstState_e state;
	logic [selWidth-1:0] owner;
	logic start;

	// idle with no fill in flight
	assign busDone = (state == StIdle) && (fill == '0);
	assign start = busDone && req[seln];
	assign sysCyc = (state == StWait);

	// ==========================================================
	// read engine
	// ==========================================================
	// seln may move while a read is out, so the owner is latched at start
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= StIdle;
			owner <= '0;
			fill <= '0;
		end else begin
			fill <= '0;
			case (state)
				StIdle: begin
					if (start) begin
						state <= StWait;
						owner <= seln;
					end
				end
				StWait: begin
					// any number of wait states before the ack
					if (sysAck) begin
						state <= StIdle;
						fill <= numChannels'(1) << owner;
					end
				end
				default: state <= StIdle;
			endcase
		end
	end

	// address and data words
	always_ff @(posedge clk) begin
		if (rst) begin
			sysAdr <= '0;
			fillData <= '0;
		end else begin
			if (start)
				sysAdr <= busReq[seln].adr;
			if (sysCyc && sysAck)
				fillData <= sysDat;
		end
	end

	// ==========================================================
	// checks
	// ==========================================================
	adrHold: assert property (@(posedge clk) disable iff (rst)
		sysCyc && !sysAck |=> sysCyc && $stable(sysAdr));

endmodule

`default_nettype wire

//--- logic/psgMixer.sv
`timescale 1ns/1ps
`default_nettype none

module psgMixer #(
	parameter int numChannels = 8
) (
	input logic clk,
	input logic rst,
	input logic ce,
	input psgPkg::psgSample_t sample [numChannels],
	input psgPkg::psgVolume_t volume [numChannels],
	output logic signed [15:0] psgOut
);

	logic signed [12:0] prod [numChannels];
	logic signed [15:0] mixSum;

	// ==========================================================
	// scaling
	// ==========================================================
	// signed sample times unsigned volume fits in 13 bits
	always_comb begin
		for (int i = 0; i < numChannels; i++) begin
			prod[i] = sample[i] * $signed({1'b0, volume[i]});
		end
	end

	// ==========================================================
	// sum
	// ==========================================================
	// eight full-scale channels stay inside 16 bits, more can wrap
	always_comb begin
		mixSum = '0;
		for (int i = 0; i < numChannels; i++) begin
			mixSum = mixSum + prod[i];
		end
	end

	// output moves at the sample rate only
	always_ff @(posedge clk) begin
		if (rst)
			psgOut <= '0;
		else if (ce)
			psgOut <= mixSum;
	end

endmodule

`default_nettype wire

//--- logic/psgPkg.sv
`default_nettype none

package psgPkg;

	// ==========================================================
	// widths
	// ==========================================================
	localparam int psgAdrWidth = 16;
	localparam int psgIdxWidth = 6;
	// the sample index is the top psgIdxWidth bits of the phase
	localparam int psgPhaseWidth = 20;

	// ==========================================================
	// sample and register types
	// ==========================================================
	typedef logic signed [7:0] psgSample_t;
	typedef logic [3:0] psgVolume_t;

	// shape settings, msb first
	typedef struct packed {
		logic [9:0] waveBase;
		logic [1:0] lenLog;
		psgVolume_t volume;
	} psgShape_s;

	// one register word, read as a phase step or as shape settings
	typedef union packed {
		logic [15:0] freqView;
		psgShape_s shapeView;
	} psgCfgWord_u;

	typedef enum logic {
		CfgFreq = 1'b0,
		CfgShape = 1'b1
	} psgCfgSel_e;

	typedef struct packed {
		logic we;
		logic [2:0] chan;
		psgCfgSel_e sel;
		psgCfgWord_u word;
	} psgCfgWrite_s;

	// address is waveBase * 64 plus the sample index
	typedef struct packed {
		logic [psgAdrWidth-1:0] adr;
	} psgBusReq_s;

endpackage

`default_nettype wire

//--- logic/psgWaveChannel.sv
`timescale 1ns/1ps
`default_nettype none

module psgWaveChannel (
	input logic clk,
	input logic rst,
	input logic ce,
	input logic cfgWe,
	input psgPkg::psgCfgSel_e cfgSel,
	input psgPkg::psgCfgWord_u cfgWord,
	input logic fill,
	input psgPkg::psgSample_t fillData,
	output logic req,
	output psgPkg::psgBusReq_s busReq,
	output psgPkg::psgSample_t sample,
	output psgPkg::psgVolume_t volume
);
	import psgPkg::*;

	psgCfgWord_u freqReg;
	psgCfgWord_u shapeReg;
	logic [psgPhaseWidth-1:0] phase;
	logic [psgPhaseWidth-1:0] nextPhase;
	logic [psgIdxWidth-1:0] lenMask;
	logic [psgIdxWidth-1:0] curIdx;
	logic [psgIdxWidth-1:0] nextIdx;
	logic stepNew;

	// ==========================================================
	// config registers
	// ==========================================================
	always_ff @(posedge clk) begin
		if (rst) begin
			freqReg <= '0;
			shapeReg <= '0;
		end else if (cfgWe) begin
			if (cfgSel == CfgFreq)
				freqReg <= cfgWord;
			else
				shapeReg <= cfgWord;
		end
	end

	assign volume = shapeReg.shapeView.volume;

	// ==========================================================
	// phase accumulator
	// ==========================================================
	always_comb begin
		// wave length is 8 << lenLog; at 64 the shift wraps and the mask is all ones
		lenMask = (psgIdxWidth'(8) << shapeReg.shapeView.lenLog) - psgIdxWidth'(1);
		nextPhase = phase + psgPhaseWidth'(freqReg.freqView);
		curIdx = phase[psgPhaseWidth-1 -: psgIdxWidth] & lenMask;
		nextIdx = nextPhase[psgPhaseWidth-1 -: psgIdxWidth] & lenMask;
		// a zero step never moves the index, so the channel is silent on the bus
		stepNew = ce && (nextIdx != curIdx);
	end

	always_ff @(posedge clk) begin
		if (rst)
			phase <= '0;
		else if (ce)
			phase <= nextPhase;
	end

	// ==========================================================
	// fetch request
	// ==========================================================
	always_ff @(posedge clk) begin
		if (rst) begin
			req <= 1'b0;
			busReq <= '0;
		end else begin
			if (fill)
				req <= 1'b0;
			// new index while a read is still out is skipped
			if (stepNew && (!req || fill)) begin
				req <= 1'b1;
				busReq.adr <= {shapeReg.shapeView.waveBase, nextIdx};
			end
		end
	end

	// sample register
	always_ff @(posedge clk) begin
		if (rst)
			sample <= '0;
		else if (fill)
			sample <= fillData;
	end

	// address must not move under the bus master
	reqHold: assert property (@(posedge clk) disable iff (rst)
		req && !fill |=> req && $stable(busReq));

endmodule

`default_nettype wire

//--- logic/psgWaveFetch.sv
`timescale 1ns/1ps
`default_nettype none

module psgWaveFetch #(
	parameter int numChannels = 8,
	localparam int selWidth = (numChannels > 1) ? $clog2(numChannels) : 1
) (
	input logic clk,
	input logic rst,
	input logic ce,
	input psgPkg::psgCfgWrite_s cfg,
	output logic sysCyc,
	output logic [psgPkg::psgAdrWidth-1:0] sysAdr,
	input logic sysAck,
	input psgPkg::psgSample_t sysDat,
	output logic signed [15:0] psgOut
);
	import psgPkg::*;

	logic [numChannels-1:0] chanWe;
	logic [numChannels-1:0] req;
	logic [numChannels-1:0] fill;
	logic [numChannels-1:0] grant;
	logic [selWidth-1:0] seln;
	logic busDone;
	psgBusReq_s busReq [numChannels];
	psgSample_t sample [numChannels];
	psgVolume_t volume [numChannels];
	psgSample_t fillData;

	// one write strobe per channel
	always_comb begin
		for (int i = 0; i < numChannels; i++) begin
			chanWe[i] = cfg.we && (cfg.chan == 3'(i));
		end
	end

	// ==========================================================
	// channels
	// ==========================================================
	for (genvar c = 0; c < numChannels; c++) begin : gChan
		psgWaveChannel u_chan (
			.clk(clk),
			.rst(rst),
			.ce(ce),
			.cfgWe(chanWe[c]),
			.cfgSel(cfg.sel),
			.cfgWord(cfg.word),
			.fill(fill[c]),
			.fillData(fillData),
			.req(req[c]),
			.busReq(busReq[c]),
			.sample(sample[c]),
			.volume(volume[c])
		);
	end

	// ==========================================================
	// bus side
	// ==========================================================
	psgBusArb #(.numChannels(numChannels)) u_arb (
		.clk(clk),
		.rst(rst),
		.ce(ce),
		.busDone(busDone),
		.req(req),
		.sel(grant),
		.seln(seln)
	);

	psgBusMaster #(.numChannels(numChannels)) u_master (
		.clk(clk),
		.rst(rst),
		.seln(seln),
		.req(req),
		.busReq(busReq),
		.sysAck(sysAck),
		.sysDat(sysDat),
		.sysCyc(sysCyc),
		.sysAdr(sysAdr),
		.fill(fill),
		.fillData(fillData),
		.busDone(busDone)
	);

	psgMixer #(.numChannels(numChannels)) u_mixer (
		.clk(clk),
		.rst(rst),
		.ce(ce),
		.sample(sample),
		.volume(volume),
		.psgOut(psgOut)
	);

	// an idle bus with a granted request starts a read in the next cycle
	grantStart: assert property (@(posedge clk) disable iff (rst)
		busDone && ((grant & req) != '0) |=> sysCyc);

	// data only goes back to a channel that asked for it
	fillPending: assert property (@(posedge clk) disable iff (rst)
		(fill & ~req) == '0);

endmodule

`default_nettype wire

//--- src.f
logic/psgPkg.sv
logic/psgBusArb.sv
logic/psgWaveChannel.sv
logic/psgBusMaster.sv
logic/psgMixer.sv
logic/psgWaveFetch.sv
verification/psgWaveFetchTb.sv

//--- verification/psgWaveFetchTb.sv
`timescale 1ns/1ps
`default_nettype none

module psgWaveFetchTb;
	import psgPkg::*;

	localparam int clkPeriod = 100;
	localparam int tblLen = 26;
	localparam int adrLen = 18;

	// one row is either a config write or a run of ce pulses with its expected reads
	typedef struct packed {
		logic isWrite;
		logic [2:0] chan;
		psgCfgSel_e sel;
		psgCfgWord_u word;
		logic [3:0] pulses;
		logic [3:0] adrCount;
		logic mixChk;
		logic soloChk;
		logic signed [15:0] mix;
	} tblEntry_s;

	logic clk = 1'b0;
	logic rst;
	logic ce;
	psgCfgWrite_s cfg;
	logic sysCyc;
	logic [psgAdrWidth-1:0] sysAdr;
	logic sysAck;
	psgSample_t sysDat;
	logic signed [15:0] psgOut;

	// memory model and bus monitor state
	logic [31:0] lfsr = 32'h55e08fb5;
	logic [1:0] waitLeft = 2'd0;
	logic inCycle = 1'b0;
	logic ackSent = 1'b0;
	logic [psgAdrWidth-1:0] curAdr;
	logic [psgAdrWidth-1:0] seenAdr [$];
	int readsStarted = 0;
	int readsAcked = 0;

	// ==========================================================
	// scenario table
	// ==========================================================
	// shape words are {waveBase, lenLog, volume}
	localparam tblEntry_s tbl [tblLen] = '{
		'{1'b0, 3'd0, CfgFreq, 16'h0000, 4'd3, 4'd0, 1'b1, 1'b0, 16'sd0},
		'{1'b1, 3'd0, CfgShape, 16'h0403, 4'd0, 4'd0, 1'b0, 1'b0, 16'sd0},
		'{1'b1, 3'd0, CfgFreq, 16'h4000, 4'd0, 4'd0, 1'b0, 1'b0, 16'sd0},
		'{1'b0, 3'd0, CfgFreq, 16'h0000, 4'd7, 4'd7, 1'b0, 1'b0, 16'sd0},
		'{1'b0, 3'd0, CfgFreq, 16'h0000, 4'd2, 4'd2, 1'b1, 1'b0, -16'sd285},
		'{1'b1, 3'd0, CfgFreq, 16'h8000, 4'd0, 4'd0, 1'b0, 1'b0, 16'sd0},
		'{1'b0, 3'd0, CfgFreq, 16'h0000, 4'd3, 4'd3, 1'b1, 1'b0, -16'sd276},
		'{1'b1, 3'd0, CfgShape, 16'h0815, 4'd0, 4'd0, 1'b0, 1'b0, 16'sd0},
		'{1'b0, 3'd0, CfgFreq, 16'h0000, 4'd3, 4'd3, 1'b1, 1'b0, -16'sd410},
		'{1'b1, 3'd0, CfgFreq, 16'h0000, 4'd0, 4'd0, 1'b0, 1'b0, 16'sd0},
		'{1'b1, 3'd1, CfgShape, 16'h1072, 4'd0, 4'd0, 1'b0, 1'b0, 16'sd0},
		'{1'b1, 3'd2, CfgShape, 16'h20B7, 4'd0, 4'd0, 1'b0, 1'b0, 16'sd0},
		'{1'b1, 3'd3, CfgShape, 16'h30F1, 4'd0, 4'd0, 1'b0, 1'b0, 16'sd0},
		'{1'b1, 3'd3, CfgFreq, 16'h4000, 4'd0, 4'd0, 1'b0, 1'b0, 16'sd0},
		'{1'b1, 3'd2, CfgFreq, 16'h4000, 4'd0, 4'd0, 1'b0, 1'b0, 16'sd0},
		'{1'b1, 3'd1, CfgFreq, 16'h4000, 4'd0, 4'd0, 1'b0, 1'b0, 16'sd0},
		'{1'b0, 3'd0, CfgFreq, 16'h0000, 4'd1, 4'd0, 1'b0, 1'b0, 16'sd0},
		'{1'b1, 3'd1, CfgFreq, 16'h0000, 4'd0, 4'd0, 1'b0, 1'b0, 16'sd0},
		'{1'b1, 3'd2, CfgFreq, 16'h0000, 4'd0, 4'd0, 1'b0, 1'b0, 16'sd0},
		'{1'b1, 3'd3, CfgFreq, 16'h0000, 4'd0, 4'd0, 1'b0, 1'b0, 16'sd0},
		'{1'b0, 3'd0, CfgFreq, 16'h0000, 4'd3, 4'd3, 1'b0, 1'b0, 16'sd0},
		'{1'b0, 3'd0, CfgFreq, 16'h0000, 4'd1, 4'd0, 1'b1, 1'b0, -16'sd352},
		'{1'b1, 3'd0, CfgShape, 16'h0810, 4'd0, 4'd0, 1'b0, 1'b0, 16'sd0},
		'{1'b1, 3'd1, CfgShape, 16'h1070, 4'd0, 4'd0, 1'b0, 1'b0, 16'sd0},
		'{1'b1, 3'd2, CfgShape, 16'h20B0, 4'd0, 4'd0, 1'b0, 1'b0, 16'sd0},
		'{1'b0, 3'd0, CfgFreq, 16'h0000, 4'd1, 4'd0, 1'b1, 1'b1, 16'sd84}
	};

	// reads in bus order, consumed row by row
	localparam logic [psgAdrWidth-1:0] adrList [adrLen] = '{
		16'h0401, 16'h0402, 16'h0403, 16'h0404, 16'h0405, 16'h0406,
		16'h0407, 16'h0400, 16'h0401, 16'h0403, 16'h0405, 16'h0407,
		16'h0801, 16'h0803, 16'h0805, 16'h1041, 16'h2081, 16'h30C1
	};

	psgWaveFetch #(.numChannels(8)) u_dut (
		.clk(clk),
		.rst(rst),
		.ce(ce),
		.cfg(cfg),
		.sysCyc(sysCyc),
		.sysAdr(sysAdr),
		.sysAck(sysAck),
		.sysDat(sysDat),
		.psgOut(psgOut)
	);

	always #(clkPeriod / 2) clk = ~clk;

	// ==========================================================
	// helpers
	// ==========================================================
	// taps 32, 22, 2, 1
	function automatic logic [31:0] lfsrNext(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// memory content, folded over both address bytes
	function automatic psgSample_t memData(input logic [psgAdrWidth-1:0] adr);
		return psgSample_t'(adr[7:0] ^ adr[15:8] ^ 8'hA5);
	endfunction

	task automatic stopRun(input string why);
		$display("%s", why);
		$display(">>> FAIL");
		$fatal(1, "simulation stopped on the first error");
	endtask

	task automatic checkAdr(input logic [psgAdrWidth-1:0] got,
			input logic [psgAdrWidth-1:0] exp, input string what);
		if (got !== exp)
			stopRun($sformatf("[FAIL] t=%0t %s: got %h, expected %h", $time, what, got, exp));
	endtask

	task automatic checkSample(input psgSample_t got, input psgSample_t exp, input string what);
		if (got !== exp)
			stopRun($sformatf("[FAIL] t=%0t %s: got %0d, expected %0d", $time, what, got, exp));
	endtask

	task automatic checkMix(input logic signed [15:0] got, input logic signed [15:0] exp,
			input string what);
		if (got !== exp)
			stopRun($sformatf("[FAIL] t=%0t %s: got %0d, expected %0d", $time, what, got, exp));
	endtask

	task automatic writeCfg(input tblEntry_s e);
		@(posedge clk);
		#1;
		cfg.we = 1'b1;
		cfg.chan = e.chan;
		cfg.sel = e.sel;
		cfg.word = e.word;
		@(posedge clk);
		#1;
		cfg.we = 1'b0;
	endtask

	task automatic pulseCe();
		int quiet;
		@(posedge clk);
		#1;
		ce = 1'b1;
		@(posedge clk);
		#1;
		ce = 1'b0;
		// next pulse only after the bus has stayed idle for 8 cycles
		quiet = 0;
		while (quiet < 8) begin
			@(posedge clk);
			#1;
			if (sysCyc)
				quiet = 0;
			else
				quiet++;
		end
	endtask

	// ==========================================================
	// memory model
	// ==========================================================
	always @(posedge clk) begin
		#1;
		if (ackSent) begin
			sysAck = 1'b0;
			ackSent = 1'b0;
			if (sysCyc)
				stopRun("bus cycle still open in the cycle after its acknowledge");
		end else if (sysCyc) begin
			if (!inCycle) begin
				inCycle = 1'b1;
				curAdr = sysAdr;
				seenAdr.push_back(sysAdr);
				readsStarted++;
				// 0 to 3 wait states, two lfsr bits each
				lfsr = lfsrNext(lfsr);
				waitLeft[1] = lfsr[0];
				lfsr = lfsrNext(lfsr);
				waitLeft[0] = lfsr[0];
			end else begin
				checkAdr(sysAdr, curAdr, "sysAdr during wait state");
			end
			if (waitLeft == 2'd0) begin
				sysDat = memData(sysAdr);
				sysAck = 1'b1;
				ackSent = 1'b1;
				inCycle = 1'b0;
				readsAcked++;
			end else begin
				waitLeft = waitLeft - 2'd1;
			end
		end
	end

	initial begin
		#((tblLen * 200 + 8) * clkPeriod);
		stopRun("watchdog expired before the scenario table finished");
	end

	// ==========================================================
	// main sequence
	// ==========================================================
	initial begin
		tblEntry_s ent;
		int adrPos;
		logic [psgAdrWidth-1:0] lastAdr;
		rst = 1'b1;
		ce = 1'b0;
		cfg = '0;
		sysAck = 1'b0;
		sysDat = '0;
		adrPos = 0;
		lastAdr = '0;
		repeat (8) @(posedge clk);
		#1;
		rst = 1'b0;
		if (sysCyc !== 1'b0)
			stopRun("sysCyc is not low after reset");
		checkMix(psgOut, 16'sd0, "psgOut after reset");

		for (int i = 0; i < tblLen; i++) begin
			ent = tbl[i];
			if (ent.isWrite) begin
				writeCfg(ent);
			end else begin
				seenAdr.delete();
				for (int p = 0; p < int'(ent.pulses); p++)
					pulseCe();
				if (seenAdr.size() != int'(ent.adrCount))
					stopRun($sformatf("[FAIL] t=%0t row %0d: %0d reads, expected %0d",
						$time, i, seenAdr.size(), ent.adrCount));
				for (int a = 0; a < int'(ent.adrCount); a++) begin
					checkAdr(seenAdr[a], adrList[adrPos], $sformatf("row %0d read %0d", i, a));
					lastAdr = adrList[adrPos];
					adrPos++;
				end
				if (readsStarted != readsAcked)
					stopRun("a bus read was started but never acknowledged");
				// lone channel at volume 1 shows its sample directly
				if (ent.soloChk)
					checkSample(psgSample_t'(psgOut), memData(lastAdr), "solo sample");
				if (ent.mixChk)
					checkMix(psgOut, ent.mix, $sformatf("row %0d mix", i));
			end
		end
		if (adrPos != adrLen) begin
			stopRun("the scenario table did not use every expected address");
		end else begin
			$display(">>> PASS");
			$finish;
		end
	end

endmodule

`default_nettype wire
